// ==== all.f ====
hdl/fsctl_pkg.sv
hdl/fsctl_regbank.sv
hdl/fsctl_frame_commit.sv
hdl/fsctl_stream_irq.sv
hdl/fsctl_top.sv
verification/fsctl_tb.sv

// ==== verification/fsctl_tb.sv ====
`default_nettype none

module fsctl_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fsctl_pkg::*;

	typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_FSYNC, OP_WR_DONE, OP_WAIT} op_e;

	// exp holds o_rd_en for writes, read data, o_stream_resetn for fsync, o_intr otherwise
	typedef struct packed {
		op_e         op;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [31:0] exp;
	} step_t;

	logic                                          o_clk;
	logic                                          o_resetn;
	reg_wr_t                                       i_wr;
	logic                                          i_rd_valid;
	reg_addr_e                                     i_rd_addr;
	logic                                          o_rd_valid;
	logic [DATA_WIDTH-1:0]                         o_rd_data;
	logic                                          i_fsync;
	logic                                          o_fsync;
	logic                                          o_out_ce;
	logic                                          o_soft_resetn;
	stream_cfg_t [NUM_STREAMS-1:0]                 o_stream_cfg;
	logic [NUM_STREAMS-1:0]                        o_stream_resetn;
	logic [NUM_STREAMS-1:0]                        i_wr_done;
	logic [NUM_STREAMS-1:0]                        o_rd_en;
	logic [NUM_STREAMS-1:0][BUF_IDX_WIDTH-1:0]     i_rd_buf_idx;
	logic                                          o_intr;

	step_t                         steps[$];
	string                         step_names[$];
	stream_cfg_t [NUM_STREAMS-1:0] staged_m;
	stream_cfg_t [NUM_STREAMS-1:0] active_m;
	logic                          cfging_m;
	logic                          soft_resetn_m;
	logic                          out_ce_m;
	int                            mismatches = 0;
	int                            failures = 0;
	int                            cycles = 0;
	int                            cycle_limit = 0;

	fsctl_top fsctl_top_i (
		.o_clk           (o_clk),
		.o_resetn        (o_resetn),
		.i_wr            (i_wr),
		.i_rd_valid      (i_rd_valid),
		.i_rd_addr       (i_rd_addr),
		.o_rd_valid      (o_rd_valid),
		.o_rd_data       (o_rd_data),
		.i_fsync         (i_fsync),
		.o_fsync         (o_fsync),
		.o_out_ce        (o_out_ce),
		.o_soft_resetn   (o_soft_resetn),
		.o_stream_cfg    (o_stream_cfg),
		.o_stream_resetn (o_stream_resetn),
		.i_wr_done       (i_wr_done),
		.o_rd_en         (o_rd_en),
		.i_rd_buf_idx    (i_rd_buf_idx),
		.o_intr          (o_intr)
	);

	always #2 o_clk = ~o_clk;

	always @(posedge o_clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			$display("tests failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// checks and reference model
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		assert (exp === act) else begin
			mismatches++;
			$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("%s", what);
	endtask

	// staged copy per register map, size pairs are low 12 / bits 27..16
	task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
		int s;
		logic [11:0] lo;
		logic [11:0] hi;
		lo = data[11:0];
		hi = data[27:16];
		if (addr == REG_CTRL) begin
			soft_resetn_m = data[0];
			cfging_m = data[1];
		end
		if (addr == REG_DST_BMP) begin
			staged_m[0].dst_bmp = data[1:0];
			staged_m[1].dst_bmp = data[5:4];
		end
		if (addr >= 8'd5 && addr <= 8'd14) begin
			s = (addr - 5) / 5;
			case ((addr - 5) % 5)
				0: {staged_m[s].height, staged_m[s].width} = {hi, lo};
				1: {staged_m[s].win_top, staged_m[s].win_left} = {hi, lo};
				2: {staged_m[s].win_height, staged_m[s].win_width} = {hi, lo};
				3: {staged_m[s].dst_top, staged_m[s].dst_left} = {hi, lo};
				default: {staged_m[s].dst_height, staged_m[s].dst_width} = {hi, lo};
			endcase
		end
	endtask

	task automatic add_step(input string name, input op_e op, input logic [7:0] addr,
			input logic [31:0] data, input logic [31:0] exp);
		step_t st;
		st.op = op;
		st.addr = addr;
		st.data = data;
		st.exp = exp;
		steps.push_back(st);
		step_names.push_back(name);
	endtask

	// ------------------------------------------------------------
	// step drivers
	// ------------------------------------------------------------
	task automatic do_write(input string name, input step_t st);
		i_wr.valid = 1'b1;
		i_wr.addr = reg_addr_e'(st.addr);
		i_wr.data = st.data;
		@(negedge o_clk);
		i_wr.valid = 1'b0;
		model_write(st.addr, st.data);
		check_value({name, " rd_en"}, st.exp, o_rd_en);
		check_value({name, " soft_resetn"}, soft_resetn_m, o_soft_resetn);
		@(negedge o_clk);
		assert (o_rd_en == '0) else
			report_failure($sformatf("%s: o_rd_en stayed high past one cycle", name));
	endtask

	// data drives the buffer index inputs during the read
	task automatic do_read(input string name, input step_t st);
		int waited;
		i_rd_buf_idx = st.data[3:0];
		i_rd_addr = reg_addr_e'(st.addr);
		i_rd_valid = 1'b1;
		@(negedge o_clk);
		i_rd_valid = 1'b0;
		waited = 0;
		while (!o_rd_valid && waited < 4) begin
			@(negedge o_clk);
			waited++;
		end
		assert (o_rd_valid) else
			report_failure($sformatf("%s: read response never arrived", name));
		check_value(name, st.exp, o_rd_data);
	endtask

	task automatic do_fsync(input string name, input step_t st);
		int waited;
		for (int s = 0; s < NUM_STREAMS; s++)
			check_value($sformatf("%s cfg%0d before", name, s), active_m[s], o_stream_cfg[s]);
		i_fsync = 1'b1;
		waited = 0;
		@(negedge o_clk);
		while (!o_fsync && waited < 6) begin
			@(negedge o_clk);
			waited++;
		end
		assert (o_fsync) else
			report_failure($sformatf("%s: o_fsync never pulsed", name));
		if (!cfging_m)
			active_m = staged_m;
		for (int s = 0; s < NUM_STREAMS; s++)
			check_value($sformatf("%s cfg%0d", name, s), active_m[s], o_stream_cfg[s]);
		check_value({name, " stream_resetn"}, st.exp, o_stream_resetn);
		// output enable only follows the first pulse
		check_value({name, " out_ce"}, out_ce_m, o_out_ce);
		@(negedge o_clk);
		i_fsync = 1'b0;
		out_ce_m = 1'b1;
		assert (!o_fsync) else
			report_failure($sformatf("%s: o_fsync was high for two cycles", name));
		assert (o_out_ce) else
			report_failure($sformatf("%s: o_out_ce did not rise after o_fsync", name));
	endtask

	// one-cycle pulse, state lands two edges later
	task automatic do_wr_done(input string name, input step_t st);
		i_wr_done[st.addr[0]] = 1'b1;
		@(negedge o_clk);
		i_wr_done[st.addr[0]] = 1'b0;
		@(negedge o_clk);
		check_value(name, st.exp, o_intr);
	endtask

	// ------------------------------------------------------------
	// stimulus table and main sequence
	// ------------------------------------------------------------
	initial begin
		logic [31:0] geo;
		logic [3:0]  idx;
		void'($urandom(32'h1202));
		o_clk = 1'b0;
		o_resetn = 1'b0;
		i_wr = '0;
		i_rd_valid = 1'b0;
		i_rd_addr = REG_CTRL;
		i_fsync = 1'b0;
		i_wr_done = '0;
		i_rd_buf_idx = '0;
		staged_m = '0;
		active_m = '0;
		cfging_m = 1'b0;
		soft_resetn_m = 1'b0;
		out_ce_m = 1'b0;

		add_step("version", OP_READ, REG_VERSION, 0, CORE_VERSION);
		add_step("unmapped", OP_READ, 8'h40, 0, 0);
		add_step("ctrl_reset", OP_READ, REG_CTRL, 0, 0);
		for (int s = 0; s < NUM_STREAMS; s++) begin
			for (int k = 0; k < 5; k++) begin
				geo = $urandom();
				add_step($sformatf("geo_wr_%0d_%0d", s, k), OP_WRITE, 5 + 5 * s + k, geo, 0);
				add_step($sformatf("geo_rd_%0d_%0d", s, k), OP_READ, 5 + 5 * s + k, 0,
					geo & 32'h0FFF_0FFF);
			end
		end
		add_step("bmp_wr", OP_WRITE, REG_DST_BMP, 32'hFFFF_FF03, 0);
		add_step("bmp_rd", OP_READ, REG_DST_BMP, 0, 32'h03);
		add_step("first_commit", OP_FSYNC, 0, 0, 32'h1);
		add_step("cfging_on", OP_WRITE, REG_CTRL, 32'h3, 0);
		add_step("s0_size_held", OP_WRITE, REG_S0_SIZE, $urandom(), 0);
		add_step("bmp_held", OP_WRITE, REG_DST_BMP, 32'h10, 0);
		add_step("cfging_rd", OP_READ, REG_CTRL, 0, 32'h3);
		add_step("held_commit", OP_FSYNC, 0, 0, 32'h1);
		add_step("cfging_off", OP_WRITE, REG_CTRL, 32'h0, 0);
		add_step("late_commit", OP_FSYNC, 0, 0, 32'h2);
		add_step("irq_en_wr", OP_WRITE, REG_IRQ_EN, 32'h01, 0);
		add_step("irq_en_rd", OP_READ, REG_IRQ_EN, 0, 32'h01);
		add_step("done_s1_masked", OP_WR_DONE, 1, 0, 0);
		add_step("state_s1", OP_READ, REG_IRQ_STATE, 0, 32'h10);
		add_step("done_s0", OP_WR_DONE, 0, 0, 1);
		add_step("state_both", OP_READ, REG_IRQ_STATE, 0, 32'h11);
		add_step("clear_s0", OP_WRITE, REG_IRQ_STATE, 32'h01, 32'h1);
		add_step("intr_cleared", OP_WAIT, 0, 1, 0);
		add_step("state_after_s0", OP_READ, REG_IRQ_STATE, 0, 32'h10);
		add_step("clear_s1", OP_WRITE, REG_IRQ_STATE, 32'h10, 32'h2);
		add_step("state_empty", OP_READ, REG_IRQ_STATE, 0, 0);
		for (int n = 0; n < 4; n++) begin
			idx = $urandom();
			add_step($sformatf("buf_idx_%0d", n), OP_READ, REG_BUF_IDX, idx,
				{26'b0, idx[3:2], 2'b0, idx[1:0]});
		end
		cycle_limit = steps.size() * 12 + 10;

		repeat (10) @(negedge o_clk);
		o_resetn = 1'b1;
		@(negedge o_clk);
		assert (!o_fsync && !o_out_ce && !o_intr && o_stream_resetn == '0 && o_rd_en == '0
				&& !o_rd_valid && !o_soft_resetn) else
			report_failure("outputs were not cleared by reset");

		foreach (steps[i]) begin
			case (steps[i].op)
				OP_WRITE:   do_write(step_names[i], steps[i]);
				OP_READ:    do_read(step_names[i], steps[i]);
				OP_FSYNC:   do_fsync(step_names[i], steps[i]);
				OP_WR_DONE: do_wr_done(step_names[i], steps[i]);
				default: begin
					repeat (steps[i].data) @(negedge o_clk);
					check_value(step_names[i], steps[i].exp, o_intr);
				end
			endcase
		end

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/fsctl_top.sv ====
`default_nettype none

module fsctl_top (
	input  wire                                   o_clk,
	input  wire                                   o_resetn,
	input  wire fsctl_pkg::reg_wr_t               i_wr,
	input  wire                                   i_rd_valid,
	input  wire fsctl_pkg::reg_addr_e             i_rd_addr,
	output wire                                   o_rd_valid,
	output wire [fsctl_pkg::DATA_WIDTH-1:0]       o_rd_data,
	input  wire                                   i_fsync,
	output wire                                   o_fsync,
	output wire                                   o_out_ce,
	output wire                                   o_soft_resetn,
	output wire fsctl_pkg::stream_cfg_t [fsctl_pkg::NUM_STREAMS-1:0] o_stream_cfg,
	output wire [fsctl_pkg::NUM_STREAMS-1:0]      o_stream_resetn,
	input  wire [fsctl_pkg::NUM_STREAMS-1:0]      i_wr_done,
	output wire [fsctl_pkg::NUM_STREAMS-1:0]      o_rd_en,
	input  wire [fsctl_pkg::NUM_STREAMS-1:0][fsctl_pkg::BUF_IDX_WIDTH-1:0] i_rd_buf_idx,
	output wire                                   o_intr
);
	import fsctl_pkg::*;

	stream_cfg_t [NUM_STREAMS-1:0] staged_cfg;
	logic                          cfging;
	irq_wr_t                       irq_wr;
	logic [NUM_STREAMS-1:0]        irq_en;
	logic [NUM_STREAMS-1:0]        irq_state;

	fsctl_regbank fsctl_regbank_i (
		.o_clk         (o_clk),
		.o_resetn      (o_resetn),
		.i_wr          (i_wr),
		.i_rd_valid    (i_rd_valid),
		.i_rd_addr     (i_rd_addr),
		.i_irq_en      (irq_en),
		.i_irq_state   (irq_state),
		.i_rd_buf_idx  (i_rd_buf_idx),
		.o_rd_valid    (o_rd_valid),
		.o_rd_data     (o_rd_data),
		.o_soft_resetn (o_soft_resetn),
		.o_cfging      (cfging),
		.o_staged_cfg  (staged_cfg),
		.o_irq_wr      (irq_wr)
	);

	fsctl_frame_commit fsctl_frame_commit_i (
		.o_clk           (o_clk),
		.o_resetn        (o_resetn),
		.i_fsync         (i_fsync),
		.i_cfging        (cfging),
		.i_staged_cfg    (staged_cfg),
		.o_fsync         (o_fsync),
		.o_out_ce        (o_out_ce),
		.o_active_cfg    (o_stream_cfg),
		.o_stream_resetn (o_stream_resetn)
	);

	fsctl_stream_irq fsctl_stream_irq_i (
		.o_clk       (o_clk),
		.o_resetn    (o_resetn),
		.i_wr_done   (i_wr_done),
		.i_irq_wr    (irq_wr),
		.o_irq_en    (irq_en),
		.o_irq_state (irq_state),
		.o_rd_en     (o_rd_en),
		.o_intr      (o_intr)
	);

endmodule

`default_nettype wire

// ==== hdl/fsctl_stream_irq.sv ====
`default_nettype none

module fsctl_stream_irq (
	input  wire                               o_clk,
	input  wire                               o_resetn,
	input  wire [fsctl_pkg::NUM_STREAMS-1:0]  i_wr_done,
	input  wire fsctl_pkg::irq_wr_t           i_irq_wr,
	output logic [fsctl_pkg::NUM_STREAMS-1:0] o_irq_en,
	output logic [fsctl_pkg::NUM_STREAMS-1:0] o_irq_state,
	output logic [fsctl_pkg::NUM_STREAMS-1:0] o_rd_en,
	output logic                              o_intr
);
	import fsctl_pkg::*;

	logic [NUM_STREAMS-1:0] wr_done_q;
	logic [NUM_STREAMS-1:0] wr_done_prev;
	logic [NUM_STREAMS-1:0] wr_done_rise;

	// ------------------------------------------------------------
	// write-done edge detect
	// ------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			wr_done_q    <= '0;
			wr_done_prev <= '0;
		end else begin
			wr_done_q    <= i_wr_done;
			wr_done_prev <= wr_done_q;
		end
	end

	assign wr_done_rise = wr_done_q & ~wr_done_prev;

	// ------------------------------------------------------------
	// sticky state, enables and read-enable pulses
	// ------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_irq_state <= '0;
			o_irq_en    <= '0;
			o_rd_en     <= '0;
		end else begin
			// a new edge beats a clear in the same cycle
			o_irq_state <= (o_irq_state & ~i_irq_wr.clr_bits) | wr_done_rise;
			if (i_irq_wr.en_valid)
				o_irq_en <= i_irq_wr.en_bits;
			o_rd_en <= i_irq_wr.clr_bits;
		end
	end

	assign o_intr = |(o_irq_state & o_irq_en);

	a_rd_en_after_clear: assert property (@(posedge o_clk) disable iff (!o_resetn)
		(|o_rd_en) |-> $past(|i_irq_wr.clr_bits));

endmodule

`default_nettype wire

// ==== hdl/fsctl_frame_commit.sv ====
`default_nettype none

module fsctl_frame_commit (
	input  wire                                                 o_clk,
	input  wire                                                 o_resetn,
	input  wire                                                 i_fsync,
	input  wire                                                 i_cfging,
	input  wire fsctl_pkg::stream_cfg_t [fsctl_pkg::NUM_STREAMS-1:0] i_staged_cfg,
	output logic                                                o_fsync,
	output logic                                                o_out_ce,
	output fsctl_pkg::stream_cfg_t [fsctl_pkg::NUM_STREAMS-1:0] o_active_cfg,
	output logic [fsctl_pkg::NUM_STREAMS-1:0]                   o_stream_resetn
);
	import fsctl_pkg::*;

	logic fsync_sync;
	logic fsync_sync_d;
	logic fsync_rise_q;
	logic commit_q;

	// ------------------------------------------------------------
	// capture and edge detect of the external frame sync
	// ------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_sync   <= 1'b0;
			fsync_sync_d <= 1'b0;
		end else begin
			fsync_sync   <= i_fsync;
			fsync_sync_d <= fsync_sync;
		end
	end

	// configuring bit is sampled on the edge cycle
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_rise_q <= 1'b0;
			commit_q     <= 1'b0;
		end else begin
			fsync_rise_q <= fsync_sync & ~fsync_sync_d;
			commit_q     <= fsync_sync & ~fsync_sync_d & ~i_cfging;
		end
	end

	// ------------------------------------------------------------
	// outputs, config lands together with o_fsync
	// ------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_fsync  <= 1'b0;
			o_out_ce <= 1'b0;
		end else begin
			o_fsync <= fsync_rise_q;
			if (o_fsync)
				o_out_ce <= 1'b1;
		end
	end

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_active_cfg    <= '0;
			o_stream_resetn <= '0;
		end else if (commit_q) begin
			o_active_cfg <= i_staged_cfg;
			for (int s = 0; s < NUM_STREAMS; s++)
				o_stream_resetn[s] <= |i_staged_cfg[s].dst_bmp;
		end
	end

	a_fsync_single: assert property (@(posedge o_clk) disable iff (!o_resetn)
		o_fsync |=> !o_fsync);
	a_cfg_on_fsync: assert property (@(posedge o_clk) disable iff (!o_resetn)
		$changed(o_active_cfg) |-> o_fsync);

endmodule

`default_nettype wire

// ==== hdl/fsctl_regbank.sv ====
`default_nettype none

module fsctl_regbank (
	input  wire                                o_clk,
	input  wire                                o_resetn,
	input  wire fsctl_pkg::reg_wr_t            i_wr,
	input  wire                                i_rd_valid,
	input  wire fsctl_pkg::reg_addr_e          i_rd_addr,
	input  wire [fsctl_pkg::NUM_STREAMS-1:0]   i_irq_en,
	input  wire [fsctl_pkg::NUM_STREAMS-1:0]   i_irq_state,
	input  wire [fsctl_pkg::NUM_STREAMS-1:0][fsctl_pkg::BUF_IDX_WIDTH-1:0] i_rd_buf_idx,
	output logic                               o_rd_valid,
	output logic [fsctl_pkg::DATA_WIDTH-1:0]   o_rd_data,
	output logic                               o_soft_resetn,
	output logic                               o_cfging,
	output fsctl_pkg::stream_cfg_t [fsctl_pkg::NUM_STREAMS-1:0] o_staged_cfg,
	output fsctl_pkg::irq_wr_t                 o_irq_wr
);
	import fsctl_pkg::*;

	logic                          soft_resetn_q;
	logic                          cfging_q;
	stream_cfg_t [NUM_STREAMS-1:0] staged_q;
	logic [IMG_WBITS-1:0]          wr_lo;
	logic [IMG_HBITS-1:0]          wr_hi;
	logic                          rd_valid_q;
	reg_addr_e                     rd_addr_q;
	logic [DATA_WIDTH-1:0]         rd_mux;

	function automatic logic [DATA_WIDTH-1:0] size_pair(
		input logic [IMG_WBITS-1:0] lo,
		input logic [IMG_HBITS-1:0] hi
	);
		logic [DATA_WIDTH-1:0] word;
		word = '0;
		word[0 +: IMG_WBITS] = lo;
		word[PAIR_HI_LSB +: IMG_HBITS] = hi;
		return word;
	endfunction

	// position of an address inside stream s's size-pair block
	function automatic int cfg_offset(input reg_addr_e addr, input int s);
		return int'(addr) - (int'(REG_S0_SIZE) + REGS_PER_STREAM * s);
	endfunction

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------
	assign wr_lo = i_wr.data[0 +: IMG_WBITS];
	assign wr_hi = i_wr.data[PAIR_HI_LSB +: IMG_HBITS];

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			soft_resetn_q <= 1'b0;
			cfging_q      <= 1'b0;
			staged_q      <= '0;
		end else if (i_wr.valid) begin
			if (i_wr.addr == REG_CTRL) begin
				soft_resetn_q <= i_wr.data[0];
				cfging_q      <= i_wr.data[1];
			end
			for (int s = 0; s < NUM_STREAMS; s++) begin
				if (i_wr.addr == REG_DST_BMP)
					staged_q[s].dst_bmp <= i_wr.data[STREAM_STRIDE*s +: BMP_WIDTH];
				case (cfg_offset(i_wr.addr, s))
					0: {staged_q[s].height, staged_q[s].width} <= {wr_hi, wr_lo};
					1: {staged_q[s].win_top, staged_q[s].win_left} <= {wr_hi, wr_lo};
					2: {staged_q[s].win_height, staged_q[s].win_width} <= {wr_hi, wr_lo};
					3: {staged_q[s].dst_top, staged_q[s].dst_left} <= {wr_hi, wr_lo};
					4: {staged_q[s].dst_height, staged_q[s].dst_width} <= {wr_hi, wr_lo};
					default: ;
				endcase
			end
		end
	end

	// irq writes go straight through as a one-cycle strobe
	always_comb begin
		o_irq_wr = '0;
		o_irq_wr.en_valid = i_wr.valid && (i_wr.addr == REG_IRQ_EN);
		for (int s = 0; s < NUM_STREAMS; s++) begin
			o_irq_wr.en_bits[s] = i_wr.data[STREAM_STRIDE*s];
			if (i_wr.valid && (i_wr.addr == REG_IRQ_STATE))
				o_irq_wr.clr_bits[s] = i_wr.data[STREAM_STRIDE*s];
		end
	end

	// ------------------------------------------------------------
	// read side, two register stages
	// ------------------------------------------------------------
	always_comb begin
		rd_mux = '0;
		case (rd_addr_q)
			REG_CTRL:    rd_mux[1:0] = {cfging_q, soft_resetn_q};
			REG_VERSION: rd_mux = CORE_VERSION;
			default:     ;
		endcase
		for (int s = 0; s < NUM_STREAMS; s++) begin
			case (rd_addr_q)
				REG_DST_BMP: rd_mux[STREAM_STRIDE*s +: BMP_WIDTH] = staged_q[s].dst_bmp;
				REG_IRQ_EN: rd_mux[STREAM_STRIDE*s] = i_irq_en[s];
				REG_IRQ_STATE: rd_mux[STREAM_STRIDE*s] = i_irq_state[s];
				REG_BUF_IDX: rd_mux[STREAM_STRIDE*s +: BUF_IDX_WIDTH] = i_rd_buf_idx[s];
				default: ;
			endcase
			case (cfg_offset(rd_addr_q, s))
				0: rd_mux = size_pair(staged_q[s].width, staged_q[s].height);
				1: rd_mux = size_pair(staged_q[s].win_left, staged_q[s].win_top);
				2: rd_mux = size_pair(staged_q[s].win_width, staged_q[s].win_height);
				3: rd_mux = size_pair(staged_q[s].dst_left, staged_q[s].dst_top);
				4: rd_mux = size_pair(staged_q[s].dst_width, staged_q[s].dst_height);
				default: ;
			endcase
		end
	end

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			rd_valid_q <= 1'b0;
			o_rd_valid <= 1'b0;
		end else begin
			rd_valid_q <= i_rd_valid;
			o_rd_valid <= rd_valid_q;
		end
	end

	always_ff @(posedge o_clk) begin
		rd_addr_q <= i_rd_addr;
		if (rd_valid_q)
			o_rd_data <= rd_mux;
	end

	assign o_soft_resetn = soft_resetn_q;
	assign o_cfging      = cfging_q;
	assign o_staged_cfg  = staged_q;

	a_rd_response: assert property (@(posedge o_clk) disable iff (!o_resetn)
		i_rd_valid |-> ##2 o_rd_valid);
	a_rd_no_spurious: assert property (@(posedge o_clk) disable iff (!o_resetn)
		o_rd_valid |-> $past(i_rd_valid, 2));

endmodule

`default_nettype wire

// ==== hdl/fsctl_pkg.sv ====
`default_nettype none

package fsctl_pkg;

	localparam int DATA_WIDTH    = 32;
	localparam int REG_IDX_WIDTH = 8;
	localparam int IMG_WBITS     = 12;
	localparam int IMG_HBITS     = 12;
	localparam int BUF_IDX_WIDTH = 2;
	localparam int BMP_WIDTH     = 2;
	localparam int NUM_STREAMS   = 2;

	// bit spacing of per-stream fields in shared registers
	localparam int STREAM_STRIDE = 4;
	// size-pair registers carry the vertical value from here up
	localparam int PAIR_HI_LSB = 16;
	// size-pair registers per stream, starting at REG_S0_SIZE
	localparam int REGS_PER_STREAM = 5;

	localparam logic [DATA_WIDTH-1:0] CORE_VERSION = 32'hFF00_FF00;

	typedef enum logic [REG_IDX_WIDTH-1:0] {
		REG_CTRL        = 8'd0,
		REG_DST_BMP     = 8'd1,
		REG_IRQ_EN      = 8'd2,
		REG_IRQ_STATE   = 8'd3,
		REG_BUF_IDX     = 8'd4,
		REG_S0_SIZE     = 8'd5,
		REG_S0_WIN_POS  = 8'd6,
		REG_S0_WIN_SIZE = 8'd7,
		REG_S0_DST_POS  = 8'd8,
		REG_S0_DST_SIZE = 8'd9,
		REG_S1_SIZE     = 8'd10,
		REG_S1_WIN_POS  = 8'd11,
		REG_S1_WIN_SIZE = 8'd12,
		REG_S1_DST_POS  = 8'd13,
		REG_S1_DST_SIZE = 8'd14,
		REG_VERSION     = 8'd255
	} reg_addr_e;

	typedef struct packed {
		logic                  valid;
		reg_addr_e             addr;
		logic [DATA_WIDTH-1:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic [BMP_WIDTH-1:0] dst_bmp;
		logic [IMG_WBITS-1:0] width;
		logic [IMG_HBITS-1:0] height;
		logic [IMG_WBITS-1:0] win_left;
		logic [IMG_HBITS-1:0] win_top;
		logic [IMG_WBITS-1:0] win_width;
		logic [IMG_HBITS-1:0] win_height;
		logic [IMG_WBITS-1:0] dst_left;
		logic [IMG_HBITS-1:0] dst_top;
		logic [IMG_WBITS-1:0] dst_width;
		logic [IMG_HBITS-1:0] dst_height;
	} stream_cfg_t;

	// one enable write covers every stream at once
	typedef struct packed {
		logic                   en_valid;
		logic [NUM_STREAMS-1:0] en_bits;
		logic [NUM_STREAMS-1:0] clr_bits;
	} irq_wr_t;

endpackage

`default_nettype wire
